/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f vlog.f \
    --top-module bubble_loader_tb -o bubble_loader_sim
./obj_dir/bubble_loader_sim | tee sim.log

if grep -qx "Test OK" sim.log; then
    echo "simulation passed"
else
    echo "simulation did not pass"
    exit 1
fi

/* sim/bubble_loader_chk.sv */
module bubble_loader_chk
    import bubble_loader_pkg::*;
(
    input logic        MCLK,
    input logic        arst_n,
    input flash_pins_t flash,
    input buf_wr_t     buf_wr
);

    timeunit 1ns;
    timeprecision 100ps;

    // serial clock only moves inside a selected transfer
    sclk_in_select: assert property (@(posedge MCLK) disable iff (!arst_n)
        (flash.sclk != $past(flash.sclk)) |-> !flash.cs_n)
        else $error("sclk toggled while cs_n was high");

    // one cycle strobe
    strobe_single: assert property (@(posedge MCLK) disable iff (!arst_n)
        buf_wr.en |=> !buf_wr.en)
        else $error("buffer write strobe lasted two cycles");

    // reset values on the pins
    reset_idle: assert property (@(posedge MCLK)
        !arst_n |=> flash.cs_n && flash.sclk && !flash.mosi && !buf_wr.en)
        else $error("flash pins or strobe not idle after reset");

endmodule

bind bubble_loader_top bubble_loader_chk chk_i (
    .MCLK   (MCLK),
    .arst_n (arst_n),
    .flash  (flash),
    .buf_wr (buf_wr)
);

/* sim/bubble_loader_monitor.sv */
`include "bubble_loader_config.svh"

module bubble_loader_monitor
    import bubble_loader_pkg::*;
(
    input  logic        MCLK,
    input  logic        arst_n,
    input  load_req_t   req,
    input  page_t       page,
    input  image_t      image,
    input  flash_pins_t flash,
    input  buf_wr_t     buf_wr,
    output int          tests_run,
    output int          tests_failed,
    output int          error_count
);

    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [31:0] SEED   = 32'hc4bc9d02;
    localparam int          WR_MAX = 4096;

    buf_wr_t     exp_wr [WR_MAX];       // expected strobes, current load
    logic        model_map [WR_MAX];    // 1 good loop, 0 bad loop
    logic        map_valid = 1'b0;      // set once a boot has run
    logic        prev_cs;
    logic        prev_sclk;
    logic        seen_low;              // request low since last load
    logic        idle_done;
    logic        cur_page;
    image_t      cur_img;
    page_t       cur_pg;
    logic [31:0] cmd_sr;                // mosi bits seen so far
    int          cmd_cnt;
    int          n_exp;
    int          wr_cnt;
    int          err_mark;              // error count at load start
    string       cur_name;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        lfsr_next = s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);  // galois form shifting right
    endfunction

    function automatic logic [31:0] stream_seed(input image_t img, input page_t pg);
        stream_seed = SEED ^ {17'd0, img, pg};      // mixed with flash address
    endfunction

    function automatic logic content_bit(input logic [31:0] s, input page_t pg, input int off);
        if (pg == `BOOT_PAGE && off >= `BOOT_BITS)
            content_bit = ((off - `BOOT_BITS) % 9) != 4;    // bad loop about every ninth
        else
            content_bit = s[0];
    endfunction

    // fills exp_wr for one load, returns the strobe count
    function automatic int expected_write(input logic is_page, input image_t img,
                                          input page_t pg);
        logic [31:0] s;
        buf_addr_t   a;
        logic        b;
        logic        g;
        int          n;
        int          i;
        int          idx;
        int          good;
        int          rd;
        int          dof;
        s = stream_seed(img, pg);
        n = 0;
        if (!is_page)
        begin
            a = buf_addr_t'(`BOOT_BASE);
            for (i = 0; i < `BOOT_BITS + `MAP_BITS; i++)
            begin
                s = lfsr_next(s);
                b = content_bit(s, pg, i);
                exp_wr[n] = '{en: 1'b1, addr: a, data: b};
                if (i >= `BOOT_BITS)
                begin
                    idx = i - `BOOT_BITS;
                    model_map[{idx[11:4], ~idx[3:0]}] = b;  // nibble reversed store
                end
                a = a + 15'd1;
                n++;
            end
            map_valid = 1'b1;
        end
        else
        begin
            a    = buf_addr_t'(`PAGE_BASE);
            good = 0;
            rd   = 0;
            dof  = 0;
            while (good < `SYNC_LOOPS + `PAGE_BITS)
            begin
                g = !map_valid || model_map[rd];    // all loops good before any map
                rd++;
                if (!g)
                    b = 1'b0;                       // bad loop uses no flash bit
                else if (good < `SYNC_LOOPS)
                begin
                    b = 1'b1;
                    good++;
                end
                else
                begin
                    s = lfsr_next(s);
                    b = content_bit(s, pg, dof);
                    dof++;
                    good++;
                end
                exp_wr[n] = '{en: 1'b1, addr: a, data: b};
                a = a + 15'd1;
                n++;
            end
        end
        return n;
    endfunction

    task automatic value_error(input string msg);
        error_count++;
        $display("** Error at %0t ns: %s", $time, msg);
    endtask

    task automatic plain_error(input string msg);
        error_count++;
        $display("%s", msg);
    endtask

    task automatic report_test(input string name, input logic failed);
        tests_run++;
        if (failed)
            tests_failed++;
        $display("%s: %s", name, failed ? "failed" : "ok");
    endtask

    always @(posedge MCLK)
    begin
        if (!arst_n)
        begin
            prev_cs      = 1'b1;
            prev_sclk    = 1'b1;
            seen_low     = 1'b0;
            idle_done    = 1'b0;
            cmd_cnt      = 0;
            n_exp        = 0;
            wr_cnt       = 0;
            err_mark     = 0;
            tests_run    = 0;
            tests_failed = 0;
            error_count  = 0;
        end
        else
        begin
            if (!req.active)
                seen_low = 1'b1;
            if (prev_cs && !flash.cs_n)             // load starts
            begin
                if (!idle_done)
                begin
                    report_test("idle after reset, request held high", error_count != 0);
                    idle_done = 1'b1;
                end
                if (!seen_low)
                    plain_error("a load started without the request going low first");
                seen_low = 1'b0;
                cur_page = req.is_page;
                cur_img  = image;
                cur_pg   = req.is_page ? page : page_t'(`BOOT_PAGE);
                cur_name = $sformatf("load %0d, %s, image %0d, page %03h", tests_run,
                                     cur_page ? "page" : "boot", cur_img, cur_pg);
                n_exp    = expected_write(cur_page, cur_img, cur_pg);
                wr_cnt   = 0;
                cmd_cnt  = 0;
                err_mark = error_count;
            end
            if (flash.cs_n && !flash.sclk)
                plain_error("serial clock is low while the flash is deselected");
            if (!flash.cs_n && !prev_sclk && flash.sclk && cmd_cnt < `CMD_BITS)
            begin
                cmd_sr = {cmd_sr[30:0], flash.mosi};    // msb first
                cmd_cnt++;
                if (cmd_cnt == `CMD_BITS &&
                    cmd_sr != {`FLASH_READ, 2'b00, cur_img, cur_pg, 7'd0})
                    value_error($sformatf("command %08h, expected %08h", cmd_sr,
                                {`FLASH_READ, 2'b00, cur_img, cur_pg, 7'd0}));
            end
            if (buf_wr.en)
            begin
                if (flash.cs_n)
                    plain_error("the buffer was written while no load was running");
                else if (wr_cnt < n_exp && (buf_wr.addr != exp_wr[wr_cnt].addr ||
                                            buf_wr.data != exp_wr[wr_cnt].data))
                    value_error($sformatf("write %0d at %0d data %b, expected at %0d data %b",
                                wr_cnt, buf_wr.addr, buf_wr.data,
                                exp_wr[wr_cnt].addr, exp_wr[wr_cnt].data));
                wr_cnt++;
            end
            if (!prev_cs && flash.cs_n)             // load ends
            begin
                if (wr_cnt != n_exp)
                    plain_error($sformatf("%s ended after %0d buffer writes, %0d were expected",
                                cur_name, wr_cnt, n_exp));
                report_test(cur_name, error_count != err_mark);
            end
            prev_cs   = flash.cs_n;
            prev_sclk = flash.sclk;
        end
    end

endmodule

/* sim/bubble_loader_tb.sv */
`include "bubble_loader_config.svh"

module bubble_loader_tb
    import bubble_loader_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int          LOADS       = 5;
    localparam int          WATCHDOG_NS = LOADS * 9000 * 8 * 20;  // bits x cycles x period
    localparam logic [31:0] SEED        = 32'hc4bc9d02;

    logic        MCLK   = 1'b0;
    logic        arst_n = 1'b0;
    load_req_t   req    = '{active: 1'b1, is_page: 1'b1};   // high from start so no load
    page_t       page   = 12'h123;
    image_t      image  = 3'd2;
    logic        miso   = 1'b0;
    buf_wr_t     buf_wr;
    flash_pins_t flash;
    int          tests_run;
    int          tests_failed;
    int          error_count;

    logic [31:0] fl_cmd     = '0;       // flash model command register
    logic [31:0] fl_lfsr    = SEED;
    int          fl_cmd_cnt = 0;
    int          fl_off     = 0;        // data bit offset

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        lfsr_next = s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    function automatic logic [31:0] stream_seed(input image_t img, input page_t pg);
        stream_seed = SEED ^ {17'd0, img, pg};
    endfunction

    function automatic logic content_bit(input logic [31:0] s, input page_t pg, input int off);
        if (pg == `BOOT_PAGE && off >= `BOOT_BITS)
            content_bit = ((off - `BOOT_BITS) % 9) != 4;    // forced bad loops in the map
        else
            content_bit = s[0];
    endfunction

    always #10 MCLK = ~MCLK;

    // flash model takes command bits on rising sclk and drives data on falling sclk
    always @(flash.sclk or posedge flash.cs_n)
    begin
        if (flash.cs_n)
            fl_cmd_cnt = 0;
        else if (flash.sclk)
        begin
            if (fl_cmd_cnt < `CMD_BITS)
            begin
                fl_cmd = {fl_cmd[30:0], flash.mosi};
                fl_cmd_cnt++;
                fl_off  = 0;
                fl_lfsr = stream_seed(fl_cmd[21:19], fl_cmd[18:7]);  // image and page
            end
        end
        else if (fl_cmd_cnt == `CMD_BITS)
        begin
            fl_lfsr = lfsr_next(fl_lfsr);
            miso   <= content_bit(fl_lfsr, fl_cmd[18:7], fl_off);
            fl_off++;
        end
    end

    // drop request, set fields, raise it and wait for cs_n to come back
    task automatic run_load(input logic is_page, input image_t img, input page_t pg);
        req.active  = 1'b0;
        req.is_page = is_page;
        page        = pg;
        image       = img;
        repeat (3) @(negedge MCLK);
        req.active = 1'b1;
        wait (flash.cs_n == 1'b0);
        wait (flash.cs_n == 1'b1);
        repeat (4) @(negedge MCLK);
    endtask

    initial
    begin
        repeat (16) @(posedge MCLK);
        @(negedge MCLK);
        arst_n = 1'b1;
        repeat (200) @(negedge MCLK);       // request high but never seen low
        run_load(1'b1, 3'd2, 12'h123);      // no map yet
        run_load(1'b0, 3'd5, 12'h000);      // boot ignores the page field
        run_load(1'b1, 3'd5, 12'h3a7);      // masked by the map
        run_load(1'b1, 3'd5, 12'h010);
        run_load(1'b1, 3'd3, 12'hfff);      // back to back
        repeat (10) @(negedge MCLK);
        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, error_count);
        if (error_count == 0 && tests_failed == 0 && tests_run == LOADS + 1)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("timeout: the loads did not complete in time");
        $display("Test FAILED");
        $finish;
    end

    bubble_loader_top dut_i (
        .MCLK   (MCLK),
        .arst_n (arst_n),
        .req    (req),
        .page   (page),
        .image  (image),
        .miso   (miso),
        .buf_wr (buf_wr),
        .flash  (flash)
    );

    bubble_loader_monitor mon_i (
        .MCLK         (MCLK),
        .arst_n       (arst_n),
        .req          (req),
        .page         (page),
        .image        (image),
        .flash        (flash),
        .buf_wr       (buf_wr),
        .tests_run    (tests_run),
        .tests_failed (tests_failed),
        .error_count  (error_count)
    );

endmodule

/* src/bubble_loader_config.svh */
`ifndef BUBBLE_LOADER_CONFIG_SVH
`define BUBBLE_LOADER_CONFIG_SVH

// bubble format sizes in bits
`define BOOT_BITS   2656        // bootloader stream
`define MAP_BITS    1200        // bad-loop map after the bootloader
`define SYNC_LOOPS  6           // leading good loops forced to 1
`define PAGE_BITS   1024        // good loops that carry flash data

// serial flash access
`define CMD_BITS    32          // opcode plus 24 bit address
`define FLASH_READ  8'h03       // plain read without dummy cycles
`define BOOT_PAGE   12'h805     // first bootloader page in the image

// bubble buffer write bases
`define BOOT_BASE   4106        // boot and map area
`define PAGE_BASE   14336       // page area

`endif

/* src/bubble_loader_pkg.sv */
package bubble_loader_pkg;

    typedef logic [11:0] page_t;        // page number, also map index
    typedef logic [2:0]  image_t;       // image slot in flash
    typedef logic [14:0] buf_addr_t;    // bubble buffer address
    typedef logic [11:0] bit_count_t;   // loop and bit counter

    // level request from the emulator core
    typedef struct packed {
        logic active;                   // load wanted
        logic is_page;                  // 0 boot, 1 page
    } load_req_t;

    // one write into the bubble buffer
    typedef struct packed {
        logic      en;                  // single cycle strobe
        buf_addr_t addr;
        logic      data;
    } buf_wr_t;

    // serial flash outputs
    typedef struct packed {
        logic cs_n;
        logic sclk;
        logic mosi;
    } flash_pins_t;

    typedef enum logic [2:0] {
        IDLE_WAIT_LOW,                  // wait for request low
        IDLE_ARMED,                     // wait for request high
        SEND_CMD,                       // opcode and address out
        BOOT_DATA,                      // bootloader bits to buffer
        MAP_DATA,                       // map bits to buffer and table
        PAGE_SYNC,                      // sync ones through the mask
        PAGE_DATA                       // page bits through the mask
    } seq_state_t;

endpackage

/* src/bubble_loader_top.sv */
`include "bubble_loader_config.svh"

module bubble_loader_top
    import bubble_loader_pkg::*;
(
    input  logic        MCLK,
    input  logic        arst_n,
    input  load_req_t   req,
    input  page_t       page,
    input  image_t      image,
    input  logic        miso,
    output buf_wr_t     buf_wr,
    output flash_pins_t flash
);

    logic                 cmd_load;
    logic                 shift;
    logic                 deselect;
    logic [`CMD_BITS-1:0] cmd_word;
    logic                 bit_done;
    logic                 rx_bit;
    logic                 map_clear;
    logic                 map_wr;
    logic                 map_bit;
    logic                 map_rd;
    logic                 good_loop;

    // request, phases and masking
    load_sequencer u_seq (
        .MCLK      (MCLK),
        .arst_n    (arst_n),
        .req       (req),
        .page      (page),
        .image     (image),
        .bit_done  (bit_done),
        .rx_bit    (rx_bit),
        .good_loop (good_loop),
        .cmd_load  (cmd_load),
        .shift     (shift),
        .deselect  (deselect),
        .map_clear (map_clear),
        .map_wr    (map_wr),
        .map_bit   (map_bit),
        .map_rd    (map_rd),
        .cmd_word  (cmd_word),
        .buf_wr    (buf_wr)
    );

    // flash pins
    spi_flash_port u_spi (
        .MCLK     (MCLK),
        .arst_n   (arst_n),
        .cmd_load (cmd_load),
        .shift    (shift),
        .cmd_word (cmd_word),
        .deselect (deselect),
        .miso     (miso),
        .flash    (flash),
        .bit_done (bit_done),
        .rx_bit   (rx_bit)
    );

    // bad loop mask
    loop_map_table u_map (
        .MCLK      (MCLK),
        .arst_n    (arst_n),
        .map_clear (map_clear),
        .map_wr    (map_wr),
        .map_bit   (map_bit),
        .map_rd    (map_rd),
        .good_loop (good_loop)
    );

endmodule

/* src/load_sequencer.sv */
`include "bubble_loader_config.svh"

module load_sequencer
    import bubble_loader_pkg::*;
(
    input  logic                 MCLK,
    input  logic                 arst_n,
    input  load_req_t            req,
    input  page_t                page,
    input  image_t               image,
    input  logic                 bit_done,
    input  logic                 rx_bit,
    input  logic                 good_loop,
    output logic                 cmd_load,
    output logic                 shift,
    output logic                 deselect,
    output logic                 map_clear,
    output logic                 map_wr,
    output logic                 map_bit,
    output logic                 map_rd,
    output logic [`CMD_BITS-1:0] cmd_word,
    output buf_wr_t              buf_wr
);

    localparam bit_count_t CMD_LAST  = bit_count_t'(`CMD_BITS - 1);
    localparam bit_count_t BOOT_LAST = bit_count_t'(`BOOT_BITS - 1);
    localparam bit_count_t MAP_LAST  = bit_count_t'(`MAP_BITS - 1);
    localparam bit_count_t SYNC_LAST = bit_count_t'(`SYNC_LOOPS - 1);
    localparam bit_count_t PAGE_LAST = bit_count_t'(`PAGE_BITS - 1);

    seq_state_t state;
    bit_count_t cnt;                    // bits or good loops in this phase
    buf_addr_t  wr_addr;                // next buffer address
    logic       page_mode;              // latched req.is_page
    logic       rd_valid;               // good_loop valid this cycle
    page_t      cmd_page;

    assign cmd_page = req.is_page ? page : page_t'(`BOOT_PAGE);

    always_ff @(posedge MCLK or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state     <= IDLE_WAIT_LOW;
            cnt       <= '0;
            wr_addr   <= '0;
            page_mode <= 1'b0;
            rd_valid  <= 1'b0;
            cmd_load  <= 1'b0;
            shift     <= 1'b0;
            deselect  <= 1'b0;
            map_clear <= 1'b0;
            map_wr    <= 1'b0;
            map_bit   <= 1'b0;
            map_rd    <= 1'b0;
            cmd_word  <= '0;
            buf_wr    <= '0;
        end
        else
        begin
            cmd_load  <= 1'b0;          // all handshakes are pulses
            shift     <= 1'b0;
            deselect  <= 1'b0;
            map_clear <= 1'b0;
            map_wr    <= 1'b0;
            map_rd    <= 1'b0;
            buf_wr.en <= 1'b0;
            rd_valid  <= map_rd;        // table answers one cycle later
            case (state)
                IDLE_WAIT_LOW:
                    if (!req.active)
                        state <= IDLE_ARMED;
                IDLE_ARMED:
                    if (req.active)
                    begin
                        // READ, 00, image, page, 7 zero bits
                        cmd_word  <= {`FLASH_READ, 2'b00, image, cmd_page, 7'd0};
                        page_mode <= req.is_page;
                        cmd_load  <= 1'b1;
                        map_clear <= 1'b1;  // both table pointers to 0
                        cnt       <= '0;
                        state     <= SEND_CMD;
                    end
                SEND_CMD:
                    if (cmd_load)
                        shift <= 1'b1;      // first command clock
                    else if (bit_done)
                    begin
                        if (cnt == CMD_LAST)
                        begin
                            cnt <= '0;
                            if (page_mode)
                            begin
                                wr_addr <= buf_addr_t'(`PAGE_BASE);
                                map_rd  <= 1'b1;    // page starts with a map read
                                state   <= PAGE_SYNC;
                            end
                            else
                            begin
                                wr_addr <= buf_addr_t'(`BOOT_BASE);
                                shift   <= 1'b1;    // first boot bit
                                state   <= BOOT_DATA;
                            end
                        end
                        else
                        begin
                            cnt   <= cnt + 1'b1;
                            shift <= 1'b1;
                        end
                    end
                BOOT_DATA:
                    if (bit_done)
                    begin
                        buf_wr  <= '{en: 1'b1, addr: wr_addr, data: rx_bit};
                        wr_addr <= wr_addr + 1'b1;
                        shift   <= 1'b1;    // map follows without a gap
                        if (cnt == BOOT_LAST)
                        begin
                            cnt   <= '0;
                            state <= MAP_DATA;
                        end
                        else
                            cnt <= cnt + 1'b1;
                    end
                MAP_DATA:
                    if (bit_done)
                    begin
                        buf_wr  <= '{en: 1'b1, addr: wr_addr, data: rx_bit};
                        wr_addr <= wr_addr + 1'b1;
                        map_wr  <= 1'b1;    // copy into the mask table
                        map_bit <= rx_bit;
                        if (cnt == MAP_LAST)
                        begin
                            deselect <= 1'b1;   // cs_n up after the last write
                            state    <= IDLE_WAIT_LOW;
                        end
                        else
                        begin
                            cnt   <= cnt + 1'b1;
                            shift <= 1'b1;
                        end
                    end
                PAGE_SYNC:
                    if (rd_valid)
                    begin
                        // good loop gets 1, bad loop gets 0
                        buf_wr  <= '{en: 1'b1, addr: wr_addr, data: good_loop};
                        wr_addr <= wr_addr + 1'b1;
                        map_rd  <= 1'b1;
                        if (good_loop)
                        begin
                            if (cnt == SYNC_LAST)
                            begin
                                cnt   <= '0;
                                state <= PAGE_DATA;
                            end
                            else
                                cnt <= cnt + 1'b1;
                        end
                    end
                PAGE_DATA:
                    if (rd_valid)
                    begin
                        if (good_loop)
                            shift <= 1'b1;      // fetch this loop's flash bit
                        else
                        begin
                            // bad loop holds 0 and keeps the flash bit
                            buf_wr  <= '{en: 1'b1, addr: wr_addr, data: 1'b0};
                            wr_addr <= wr_addr + 1'b1;
                            map_rd  <= 1'b1;
                        end
                    end
                    else if (bit_done)
                    begin
                        buf_wr  <= '{en: 1'b1, addr: wr_addr, data: rx_bit};
                        wr_addr <= wr_addr + 1'b1;
                        if (cnt == PAGE_LAST)
                        begin
                            deselect <= 1'b1;
                            state    <= IDLE_WAIT_LOW;
                        end
                        else
                        begin
                            cnt    <= cnt + 1'b1;
                            map_rd <= 1'b1;
                        end
                    end
                default:
                    state <= IDLE_WAIT_LOW;
            endcase
        end
    end

endmodule

/* src/loop_map_table.sv */
module loop_map_table
    import bubble_loader_pkg::*;
(
    input  logic MCLK,
    input  logic arst_n,
    input  logic map_clear,
    input  logic map_wr,
    input  logic map_bit,
    input  logic map_rd,
    output logic good_loop
);

    localparam int unsigned DEPTH = 2 ** $bits(page_t);

    logic  map_mem [DEPTH];             // 1 good loop, 0 bad loop
    page_t wr_ptr;
    page_t rd_ptr;
    page_t wr_idx;
    logic  map_loaded;                  // no map yet means all loops good
    logic  map_q;

    // map is stored nibble reversed in the bubble
    assign wr_idx = {wr_ptr[11:4], ~wr_ptr[3:0]};

    always_ff @(posedge MCLK or negedge arst_n)
    begin
        if (!arst_n)
        begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            map_loaded <= 1'b0;
        end
        else if (map_clear)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end
        else
        begin
            if (map_wr)
            begin
                wr_ptr     <= wr_ptr + 1'b1;
                map_loaded <= 1'b1;
            end
            if (map_rd)
                rd_ptr <= rd_ptr + 1'b1;        // sequential walk over loops
        end
    end

    always_ff @(posedge MCLK)
    begin
        if (map_wr)
            map_mem[wr_idx] <= map_bit;
        if (map_rd)
            map_q <= map_mem[rd_ptr];           // valid one cycle after map_rd
    end

    assign good_loop = map_q | ~map_loaded;

endmodule

/* src/spi_flash_port.sv */
`include "bubble_loader_config.svh"

module spi_flash_port
    import bubble_loader_pkg::*;
(
    input  logic                 MCLK,
    input  logic                 arst_n,
    input  logic                 cmd_load,
    input  logic                 shift,
    input  logic [`CMD_BITS-1:0] cmd_word,
    input  logic                 deselect,
    input  logic                 miso,
    output flash_pins_t          flash,
    output logic                 bit_done,
    output logic                 rx_bit
);

    logic [`CMD_BITS-1:0] cmd_sr;       // command out with zero fill
    logic                 cs_n_q;
    logic                 sclk_q;
    logic                 mosi_q;
    logic                 busy;         // sclk low phase in progress
    logic                 take_bit;     // accepted shift request

    assign take_bit = shift & ~busy;

    // chip select, two phase clock and handshake
    always_ff @(posedge MCLK or negedge arst_n)
    begin
        if (!arst_n)
        begin
            cs_n_q   <= 1'b1;
            sclk_q   <= 1'b1;
            mosi_q   <= 1'b0;
            busy     <= 1'b0;
            bit_done <= 1'b0;
        end
        else
        begin
            bit_done <= 1'b0;
            if (cmd_load)
                cs_n_q <= 1'b0;                 // select until deselect
            else if (deselect)
                cs_n_q <= 1'b1;
            if (take_bit)
            begin
                sclk_q <= 1'b0;                 // falling phase
                mosi_q <= cmd_sr[`CMD_BITS-1];  // next command bit or 0 in data
                busy   <= 1'b1;
            end
            else if (busy)
            begin
                sclk_q   <= 1'b1;               // rising phase where flash latches mosi
                busy     <= 1'b0;
                bit_done <= 1'b1;               // rx_bit valid with this pulse
            end
        end
    end

    // shift register and miso sample
    always_ff @(posedge MCLK)
    begin
        if (cmd_load)
            cmd_sr <= cmd_word;
        else if (take_bit)
            cmd_sr <= {cmd_sr[`CMD_BITS-2:0], 1'b0};
        if (busy)
            rx_bit <= miso;                     // driven since falling edge
    end

    assign flash = '{cs_n: cs_n_q, sclk: sclk_q, mosi: mosi_q};

endmodule

/* vlog.f */
+incdir+src
src/bubble_loader_pkg.sv
src/spi_flash_port.sv
src/loop_map_table.sv
src/load_sequencer.sv
src/bubble_loader_top.sv
sim/bubble_loader_chk.sv
sim/bubble_loader_monitor.sv
sim/bubble_loader_tb.sv
